// File: design/blkdev_front_top.sv
/*
 * Block-device front end: mount bookkeeping for three drive slots and the
 * hard-disk request path. Single clock domain, synchronous reset dd_reset.
 * Read/write pulses reach the host as levels 2 cycles later.
 */

`timescale 1ns/1ps
`default_nettype none

module blkdev_front_top (
	input  wire logic                              clk_sys,
	input  wire logic                              dd_reset,
	input  wire logic                              hdd_read,
	input  wire logic                              hdd_write,
	input  wire logic                              sd_ack,
	input  wire logic [blkdev_pkg::NUM_SLOTS-1:0]  img_mounted,
	input  wire logic [blkdev_pkg::IMG_SIZE_W-1:0] img_size,
	input  wire logic                              img_readonly,
	output logic                                   sd_rd,
	output logic                                   sd_wr,
	output logic                                   cpu_wait,
	output logic [blkdev_pkg::NUM_FLOPPIES-1:0]    disk_mount,
	output logic [blkdev_pkg::NUM_FLOPPIES-1:0]    disk_change,
	output logic                                   hdd_mounted,
	output logic                                   hdd_protect
);

	// Between the capture stage and the sequencer
	logic rd_pending;
	logic wr_pending;
	logic take_clear;

	// ========================================================================
	// Mount bookkeeping
	// ========================================================================

	image_mount_tracker image_mount_tracker_i (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.img_readonly (img_readonly),
		.disk_mount   (disk_mount),
		.disk_change  (disk_change),
		.hdd_mounted  (hdd_mounted),
		.hdd_protect  (hdd_protect)
	);

	// ========================================================================
	// Hard-disk request path
	// ========================================================================

	hdd_request_capture hdd_request_capture_i (
		.clk_sys    (clk_sys),
		.dd_reset   (dd_reset),
		.hdd_read   (hdd_read),
		.hdd_write  (hdd_write),
		.take_clear (take_clear),
		.rd_pending (rd_pending),
		.wr_pending (wr_pending)
	);

	// Talks to the host and holds the CPU
	hdd_host_sequencer hdd_host_sequencer_i (
		.clk_sys    (clk_sys),
		.dd_reset   (dd_reset),
		.rd_pending (rd_pending),
		.wr_pending (wr_pending),
		.sd_ack     (sd_ack),
		.take_clear (take_clear),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr),
		.cpu_wait   (cpu_wait)
	);

endmodule

`default_nettype wire

// File: design/blkdev_pkg.sv
/*
 * Shared constants and types for the block-device front end.
 * Slot numbering and bus widths follow the host protocol and are not meant to be changed.
 */

`default_nettype none

package blkdev_pkg;

	// ========================================================================
	// Drive slots
	// ========================================================================

	// One mount strobe per slot on the host side
	localparam int NUM_SLOTS = 3;

	// Host slot order: floppy 1, hard disk, floppy 2
	localparam int SLOT_FLOPPY1 = 0;
	localparam int SLOT_HDD = 1;
	localparam int SLOT_FLOPPY2 = 2;

	// Floppy outputs are packed, so floppy 2 sits at index 1
	localparam int NUM_FLOPPIES = 2;

	// ========================================================================
	// Host bus widths
	// ========================================================================

	// Image size in bytes as reported by the host
	localparam int IMG_SIZE_W = 64;

	// ========================================================================
	// Hard-disk sequencer
	// ========================================================================

	// Idle waits for a pending request; busy runs until the acknowledge falls
	typedef enum logic {
		SEQ_IDLE = 1'b0,
		SEQ_BUSY = 1'b1
	} seq_state_e;

endpackage

`default_nettype wire

// File: design/hdd_host_sequencer.sv
/*
 * Second request stage: issues pending requests to the host as sd_rd/sd_wr
 * levels and stalls the CPU until the transfer ends. Read and write may be
 * issued together if both were pending. sd_ack is assumed synchronous to clk_sys.
 */

`timescale 1ns/1ps
`default_nettype none

module hdd_host_sequencer (
	input  wire logic clk_sys,
	input  wire logic dd_reset,
	input  wire logic rd_pending,
	input  wire logic wr_pending,
	input  wire logic sd_ack,
	output logic      take_clear,
	output logic      sd_rd,
	output logic      sd_wr,
	output logic      cpu_wait
);

	blkdev_pkg::seq_state_e state;

	// Acknowledge from the previous cycle, for edge detection
	logic ack_q;
	logic ack_rise;
	logic ack_fall;
	logic any_pending;

	// ========================================================================
	// Acknowledge edges
	// ========================================================================

	assign ack_rise = sd_ack & ~ack_q;
	assign ack_fall = ~sd_ack & ack_q;

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= sd_ack;
		end
	end

	// ========================================================================
	// Sequencer
	// ========================================================================

	assign any_pending = rd_pending | wr_pending;

	// Host has taken the request; lets the capture stage drop its flags
	assign take_clear = (state == blkdev_pkg::SEQ_BUSY) && ack_rise;

	// CPU stays stalled for the whole transfer, up to the acknowledge fall
	assign cpu_wait = (state == blkdev_pkg::SEQ_BUSY);

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			state <= blkdev_pkg::SEQ_IDLE;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
		end else begin
			case (state)
				blkdev_pkg::SEQ_IDLE: begin
					if (any_pending) begin
						state <= blkdev_pkg::SEQ_BUSY;
						sd_rd <= rd_pending;
						sd_wr <= wr_pending;
					end
				end
				blkdev_pkg::SEQ_BUSY: begin
					if (ack_rise) begin
						// Request levels are withdrawn as soon as the host answers
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
					end else if (ack_fall) begin
						// Transfer done, a queued request goes out on the next edge
						state <= blkdev_pkg::SEQ_IDLE;
					end
				end
				default: begin
					state <= blkdev_pkg::SEQ_IDLE;
					sd_rd <= 1'b0;
					sd_wr <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/hdd_request_capture.sv
/*
 * First request stage: turns single-cycle read and write pulses into sticky
 * pending flags. A pulse in the same cycle as take_clear is dropped.
 */

`timescale 1ns/1ps
`default_nettype none

module hdd_request_capture (
	input  wire logic clk_sys,
	input  wire logic dd_reset,
	input  wire logic hdd_read,
	input  wire logic hdd_write,
	input  wire logic take_clear,
	output logic      rd_pending,
	output logic      wr_pending
);

	// Same-kind pulses merge into one pending request
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			rd_pending <= 1'b0;
			wr_pending <= 1'b0;
		end else if (take_clear) begin
			// Host has taken the request, both kinds go together
			rd_pending <= 1'b0;
			wr_pending <= 1'b0;
		end else begin
			if (hdd_read) begin
				rd_pending <= 1'b1;
			end
			if (hdd_write) begin
				wr_pending <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/image_mount_tracker.sv
/*
 * Keeps the mount state of the two floppy slots and the hard-disk slot.
 * A zero img_size counts as an empty image. The change toggles only flip,
 * so a consumer has to compare against its own copy to see a new disk.
 */

`timescale 1ns/1ps
`default_nettype none

module image_mount_tracker (
	input  wire logic                              clk_sys,
	input  wire logic                              dd_reset,
	input  wire logic [blkdev_pkg::NUM_SLOTS-1:0]  img_mounted,
	input  wire logic [blkdev_pkg::IMG_SIZE_W-1:0] img_size,
	input  wire logic                              img_readonly,
	output logic [blkdev_pkg::NUM_FLOPPIES-1:0]    disk_mount,
	output logic [blkdev_pkg::NUM_FLOPPIES-1:0]    disk_change,
	output logic                                   hdd_mounted,
	output logic                                   hdd_protect
);

	// Shared by all slots, the host presents one size at a time
	logic img_present;

	assign img_present = |img_size;

	// ========================================================================
	// Floppy slots
	// ========================================================================

	// Floppy 1 reads slot 0, floppy 2 reads slot 2
	for (genvar i = 0; i < blkdev_pkg::NUM_FLOPPIES; i++) begin : g_floppy
		localparam int SLOT = (i == 0) ? blkdev_pkg::SLOT_FLOPPY1 :
			blkdev_pkg::SLOT_FLOPPY2;

		always_ff @(posedge clk_sys) begin
			if (dd_reset) begin
				disk_mount[i] <= 1'b0;
				disk_change[i] <= 1'b0;
			end else if (img_mounted[SLOT]) begin
				disk_mount[i] <= img_present;
				// Flips on every strobe, even a remount of the same image
				disk_change[i] <= ~disk_change[i];
			end
		end
	end

	// ========================================================================
	// Hard-disk slot
	// ========================================================================

	// No change toggle here; the sequencer fetches sectors on demand
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			hdd_mounted <= 1'b0;
			hdd_protect <= 1'b0;
		end else if (img_mounted[blkdev_pkg::SLOT_HDD]) begin
			hdd_mounted <= img_present;
			hdd_protect <= img_readonly;
		end
	end

endmodule

`default_nettype wire

// File: dv/blkdev_front_chk.sv
/*
 * Concurrent checks on the front-end ports, bound into blkdev_front_top.
 * sd_ack is taken as synchronous to clk_sys.
 */

`timescale 1ns/1ps
`default_nettype none

module blkdev_front_chk (
	input wire logic                            clk_sys,
	input wire logic                            dd_reset,
	input wire logic                            sd_ack,
	input wire logic                            sd_rd,
	input wire logic                            sd_wr,
	input wire logic                            cpu_wait,
	input wire logic [blkdev_pkg::NUM_FLOPPIES-1:0] disk_mount,
	input wire logic [blkdev_pkg::NUM_FLOPPIES-1:0] disk_change,
	input wire logic                            hdd_mounted,
	input wire logic                            hdd_protect
);

	// Number of assertion failures so far
	int assert_failures = 0;

	// Host request levels only exist inside a stalled transfer
	a_request_stalls_cpu: assert property (
		@(posedge clk_sys) disable iff (dd_reset)
		(sd_rd || sd_wr) |-> cpu_wait
	) else begin
		$error("sd_rd or sd_wr high without cpu_wait");
		assert_failures = assert_failures + 1;
	end

	// First cycle out of reset
	a_reset_values: assert property (
		@(posedge clk_sys)
		$fell(dd_reset) |-> (!sd_rd && !sd_wr && !cpu_wait && disk_mount == '0 &&
			disk_change == '0 && !hdd_mounted && !hdd_protect)
	) else begin
		$error("outputs not cleared in the cycle after reset");
		assert_failures = assert_failures + 1;
	end

	// Stall ends only on the acknowledge fall
	a_wait_ends_on_ack_fall: assert property (
		@(posedge clk_sys) disable iff (dd_reset)
		($fell(cpu_wait) && !$past(dd_reset)) |-> ($past(sd_ack, 2) && !$past(sd_ack))
	) else begin
		$error("cpu_wait fell without a sampled acknowledge fall");
		assert_failures = assert_failures + 1;
	end

endmodule

bind blkdev_front_top blkdev_front_chk blkdev_front_chk_i (
	.clk_sys     (clk_sys),
	.dd_reset    (dd_reset),
	.sd_ack      (sd_ack),
	.sd_rd       (sd_rd),
	.sd_wr       (sd_wr),
	.cpu_wait    (cpu_wait),
	.disk_mount  (disk_mount),
	.disk_change (disk_change),
	.hdd_mounted (hdd_mounted),
	.hdd_protect (hdd_protect)
);

`default_nettype wire

// File: dv/blkdev_front_tb.sv
/*
 * Testbench for the block-device front end. The host acknowledge answers after
 * 1 to 8 cycles and drops 1 to 8 cycles later. A cycle model checks every
 * output on the falling edge; the tests add directed latency checks.
 */

`timescale 1ns/1ps
`default_nettype none

module blkdev_front_tb;

	// Transaction budget per test, also sets the timeout
	localparam int N_READS = 20;
	localparam int N_WRITES = 20;
	localparam int N_QUEUED = 4;
	localparam int N_RESET = 2;
	localparam int N_MOUNTS = 30;
	localparam int CYCLE_LIMIT =
		(N_READS + N_WRITES + N_QUEUED + N_RESET + N_MOUNTS) * 40 + 100;

	logic                                  clk_sys;
	logic                                  dd_reset;
	logic                                  hdd_read;
	logic                                  hdd_write;
	logic                                  sd_ack;
	logic [blkdev_pkg::NUM_SLOTS-1:0]      img_mounted;
	logic [blkdev_pkg::IMG_SIZE_W-1:0]     img_size;
	logic                                  img_readonly;
	logic                                  sd_rd;
	logic                                  sd_wr;
	logic                                  cpu_wait;
	logic [blkdev_pkg::NUM_FLOPPIES-1:0]   disk_mount;
	logic [blkdev_pkg::NUM_FLOPPIES-1:0]   disk_change;
	logic                                  hdd_mounted;
	logic                                  hdd_protect;

	// Host side: 0 waits for a request, 1 counts to the rise, 2 counts to the fall
	int host_phase;
	int host_count;

	// Reference model state
	logic                                  model_valid;
	logic                                  m_rd_pend;
	logic                                  m_wr_pend;
	logic                                  m_busy;
	logic                                  m_sd_rd;
	logic                                  m_sd_wr;
	logic                                  m_ack_prev;
	logic [blkdev_pkg::NUM_FLOPPIES-1:0]   m_disk_mount;
	logic [blkdev_pkg::NUM_FLOPPIES-1:0]   m_disk_change;
	logic                                  m_hdd_mounted;
	logic                                  m_hdd_protect;

	int check_count;
	int error_count;
	int tests_run;
	int tests_failed;
	int cycle_count;
	int seed_value;
	int errors_before;

	blkdev_front_top blkdev_front_top_i (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.hdd_read     (hdd_read),
		.hdd_write    (hdd_write),
		.sd_ack       (sd_ack),
		.img_mounted  (img_mounted),
		.img_size     (img_size),
		.img_readonly (img_readonly),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.cpu_wait     (cpu_wait),
		.disk_mount   (disk_mount),
		.disk_change  (disk_change),
		.hdd_mounted  (hdd_mounted),
		.hdd_protect  (hdd_protect)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout: tests did not end within %0d cycles", CYCLE_LIMIT);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ========================================================================
	// Host acknowledge model
	// ========================================================================

	always @(posedge clk_sys) begin
		if (dd_reset) begin
			sd_ack <= 1'b0;
			host_phase <= 0;
			host_count <= 0;
		end else begin
			case (host_phase)
				0: begin
					if (sd_rd || sd_wr) begin
						host_phase <= 1;
						host_count <= $urandom_range(7, 0);
					end
				end
				1: begin
					if (host_count == 0) begin
						sd_ack <= 1'b1;
						host_phase <= 2;
						host_count <= $urandom_range(7, 0);
					end else begin
						host_count <= host_count - 1;
					end
				end
				default: begin
					if (host_count == 0) begin
						sd_ack <= 1'b0;
						host_phase <= 0;
					end else begin
						host_count <= host_count - 1;
					end
				end
			endcase
		end
	end

	// ========================================================================
	// Reference model and continuous compare
	// ========================================================================

	always @(posedge clk_sys) begin : model_step
		logic ack_up;
		logic ack_down;
		logic taken;

		ack_up = sd_ack && !m_ack_prev;
		ack_down = !sd_ack && m_ack_prev;
		taken = m_busy && ack_up;
		if (dd_reset) begin
			model_valid <= 1'b1;
			{m_rd_pend, m_wr_pend, m_busy, m_sd_rd, m_sd_wr, m_ack_prev} <= '0;
			m_disk_mount <= '0;
			m_disk_change <= '0;
			m_hdd_mounted <= 1'b0;
			m_hdd_protect <= 1'b0;
		end else begin
			// Issue uses the pending flags as they stood before this edge
			if (!m_busy) begin
				if (m_rd_pend || m_wr_pend) begin
					m_busy <= 1'b1;
					m_sd_rd <= m_rd_pend;
					m_sd_wr <= m_wr_pend;
				end
			end else if (ack_up) begin
				m_sd_rd <= 1'b0;
				m_sd_wr <= 1'b0;
			end else if (ack_down) begin
				m_busy <= 1'b0;
			end
			// Pulse lost when it meets the acknowledge rise
			if (taken) begin
				m_rd_pend <= 1'b0;
				m_wr_pend <= 1'b0;
			end else begin
				if (hdd_read)
					m_rd_pend <= 1'b1;
				if (hdd_write)
					m_wr_pend <= 1'b1;
			end
			m_ack_prev <= sd_ack;
			if (img_mounted[blkdev_pkg::SLOT_FLOPPY1]) begin
				m_disk_mount[0] <= |img_size;
				m_disk_change[0] <= ~m_disk_change[0];
			end
			if (img_mounted[blkdev_pkg::SLOT_FLOPPY2]) begin
				m_disk_mount[1] <= |img_size;
				m_disk_change[1] <= ~m_disk_change[1];
			end
			if (img_mounted[blkdev_pkg::SLOT_HDD]) begin
				m_hdd_mounted <= |img_size;
				m_hdd_protect <= img_readonly;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (model_valid) begin
			check_value("sd_rd", m_sd_rd, sd_rd);
			check_value("sd_wr", m_sd_wr, sd_wr);
			check_value("cpu_wait", m_busy, cpu_wait);
			check_value("disk_mount", m_disk_mount, disk_mount);
			check_value("disk_change", m_disk_change, disk_change);
			check_value("hdd_mounted", m_hdd_mounted, hdd_mounted);
			check_value("hdd_protect", m_hdd_protect, hdd_protect);
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count = check_count + 1;
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("FAILED at %0t: %s expected %0h, actual %0h", $time, name,
				expected, actual);
		end
	endtask

	// Compare mismatches plus failed bound assertions
	function automatic int failure_count();
		return error_count + blkdev_front_top_i.blkdev_front_chk_i.assert_failures;
	endfunction

	task automatic report_test(input string name, input int errs_at_start);
		tests_run = tests_run + 1;
		if (failure_count() == errs_at_start) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("Test %s: %0d errors", name, failure_count() - errs_at_start);
		end
	endtask

	// Called on a falling edge, returns on one
	task automatic wait_ack(input logic level);
		while (sd_ack !== level)
			@(negedge clk_sys);
	endtask

	task automatic wait_idle();
		@(negedge clk_sys);
		while (cpu_wait || sd_ack || sd_rd || sd_wr)
			@(negedge clk_sys);
	endtask

	task automatic pulse_request(input logic is_write);
		@(posedge clk_sys);
		if (is_write)
			hdd_write <= 1'b1;
		else
			hdd_read <= 1'b1;
		@(posedge clk_sys);
		hdd_read <= 1'b0;
		hdd_write <= 1'b0;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic run_transfers(input logic is_write, input int count);
		int    gap;
		string lvl;

		lvl = is_write ? "sd_wr" : "sd_rd";
		for (int n = 0; n < count; n++) begin
			wait_idle();
			gap = $urandom_range(3, 0);
			repeat (gap) @(posedge clk_sys);
			pulse_request(is_write);
			@(negedge clk_sys);
			check_value({lvl, " one cycle in"}, 0, is_write ? sd_wr : sd_rd);
			@(negedge clk_sys);
			check_value({lvl, " two cycles in"}, 1, is_write ? sd_wr : sd_rd);
			check_value("cpu_wait two cycles in", 1, cpu_wait);
			wait_ack(1'b1);
			@(negedge clk_sys);
			check_value({lvl, " after ack rise"}, 0, is_write ? sd_wr : sd_rd);
			check_value("cpu_wait after ack rise", 1, cpu_wait);
			wait_ack(1'b0);
			check_value("cpu_wait before ack fall sampled", 1, cpu_wait);
			@(negedge clk_sys);
			check_value("cpu_wait after ack fall", 0, cpu_wait);
		end
	endtask

	task automatic run_queued();
		// Write pulse lands on the edge that samples the acknowledge rise
		wait_idle();
		pulse_request(1'b0);
		@(posedge clk_sys);
		while (!(host_phase == 1 && host_count == 0))
			@(posedge clk_sys);
		hdd_write <= 1'b1;
		@(posedge clk_sys);
		hdd_write <= 1'b0;
		wait_idle();
		repeat (5) begin
			@(negedge clk_sys);
			check_value("sd_wr after lost pulse", 0, sd_wr);
			check_value("cpu_wait after lost pulse", 0, cpu_wait);
		end

		// Write pulse after the rise waits for the running read
		pulse_request(1'b0);
		@(negedge clk_sys);
		wait_ack(1'b1);
		pulse_request(1'b1);
		@(negedge clk_sys);
		while (cpu_wait)
			@(negedge clk_sys);
		@(negedge clk_sys);
		check_value("queued sd_wr", 1, sd_wr);
		check_value("queued sd_rd", 0, sd_rd);
		check_value("queued cpu_wait", 1, cpu_wait);
		wait_idle();
	endtask

	task automatic run_reset_mid_transfer(input int count);
		logic  is_write;
		string lvl;

		for (int n = 0; n < count; n++) begin
			is_write = (n % 2) == 1;
			lvl = is_write ? "sd_wr" : "sd_rd";
			wait_idle();
			pulse_request(is_write);
			@(negedge clk_sys);
			@(negedge clk_sys);
			check_value({lvl, " before reset"}, 1, is_write ? sd_wr : sd_rd);
			check_value("cpu_wait before reset", 1, cpu_wait);
			// Other kind is still pending when reset hits, before any ack rise
			pulse_request(!is_write);
			dd_reset <= 1'b1;
			repeat (2) @(posedge clk_sys);
			dd_reset <= 1'b0;
			repeat (12) begin
				@(negedge clk_sys);
				check_value("sd_rd after reset", 0, sd_rd);
				check_value("sd_wr after reset", 0, sd_wr);
				check_value("cpu_wait after reset", 0, cpu_wait);
			end
		end
	endtask

	task automatic run_mounts(input int count);
		logic [1:0]  exp_mount;
		logic [1:0]  exp_change;
		logic        exp_hdd;
		logic        exp_prot;
		int          slot;
		logic [63:0] size;
		logic        ro;

		// Reset test before this one left every slot empty
		exp_mount = '0;
		exp_change = '0;
		exp_hdd = 1'b0;
		exp_prot = 1'b0;
		for (int n = 0; n < count; n++) begin
			slot = $urandom_range(2, 0);
			size = ($urandom_range(3, 0) == 0) ? 64'd0 : {$urandom, $urandom};
			ro = $urandom_range(1, 0);
			@(posedge clk_sys);
			img_mounted <= 3'b001 << slot;
			img_size <= size;
			img_readonly <= ro;
			@(posedge clk_sys);
			img_mounted <= '0;
			if (slot == blkdev_pkg::SLOT_HDD) begin
				exp_hdd = (size != 0);
				exp_prot = ro;
			end else begin
				exp_mount[slot == blkdev_pkg::SLOT_FLOPPY2] = (size != 0);
				exp_change[slot == blkdev_pkg::SLOT_FLOPPY2] =
					~exp_change[slot == blkdev_pkg::SLOT_FLOPPY2];
			end
			@(negedge clk_sys);
			check_value("disk_mount after strobe", exp_mount, disk_mount);
			check_value("disk_change after strobe", exp_change, disk_change);
			check_value("hdd_mounted after strobe", exp_hdd, hdd_mounted);
			check_value("hdd_protect after strobe", exp_prot, hdd_protect);
		end
	endtask

	initial begin
		seed_value = $urandom(34525);
		check_count = 0;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		model_valid = 1'b0;
		dd_reset = 1'b1;
		hdd_read = 1'b0;
		hdd_write = 1'b0;
		sd_ack = 1'b0;
		img_mounted = '0;
		img_size = '0;
		img_readonly = 1'b0;
		repeat (5) @(posedge clk_sys);
		dd_reset <= 1'b0;

		errors_before = failure_count();
		run_transfers(1'b0, N_READS);
		report_test("random reads", errors_before);
		errors_before = failure_count();
		run_transfers(1'b1, N_WRITES);
		report_test("random writes", errors_before);
		errors_before = failure_count();
		run_queued();
		report_test("queued request", errors_before);
		errors_before = failure_count();
		run_reset_mid_transfer(N_RESET);
		report_test("reset mid-transfer", errors_before);
		errors_before = failure_count();
		run_mounts(N_MOUNTS);
		report_test("mounts", errors_before);

		$display("Tests run %0d, tests failed %0d, checks %0d, errors %0d, assertions %0d",
			tests_run, tests_failed, check_count, error_count,
			blkdev_front_top_i.blkdev_front_chk_i.assert_failures);
		if (failure_count() == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
design/blkdev_pkg.sv
design/image_mount_tracker.sv
design/hdd_request_capture.sv
design/hdd_host_sequencer.sv
design/blkdev_front_top.sv
dv/blkdev_front_chk.sv
dv/blkdev_front_tb.sv
